/* core_shell.f */
+incdir+common
common/core_shell_pkg.sv
hdl/sleep_ctrl.sv
regfile/register_file_ff.sv
icache_rams/ic_ram_1p.sv
icache_rams/ic_ram_banks.sv
hdl/core_shell_top.sv
bench/core_shell_sva.sv
bench/core_shell_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module core_shell_tb \
  --Mdir obj_dir \
  -f core_shell.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vcore_shell_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

/* bench/core_shell_tb.sv */
// Core shell testbench
// Random stimulus on sleep control, register file and cache RAMs,
// checked against a cycle model kept in the testbench

`timescale 1ns/1ps
`include "core_shell_config.svh"

module core_shell_tb import core_shell_pkg::*; ();

  localparam int unsigned NumRegs     = `CFG_RF_WORDS;
  localparam int unsigned SleepCycles = 300;
  localparam int unsigned GatedCycles = 300;
  localparam int unsigned RfCycles    = 400;
  localparam int unsigned DummyCycles = 120;
  localparam int unsigned CacheCycles = 600;
  localparam int unsigned TotalCycles = 5 + SleepCycles + GatedCycles + RfCycles + 5 +
                                        DummyCycles + IC_NUM_LINES + CacheCycles + 1;
  localparam int unsigned TimeoutNs   = (TotalCycles + 200) * 20;

  logic           clk = 1'b0;
  logic           rst_n;
  logic           test_en;
  logic           fetch_enable;
  logic           core_busy;
  wake_req_t      wake;
  logic           core_sleep;
  rf_req_t        rf_req;
  reg_data_t      rf_rdata_a;
  reg_data_t      rf_rdata_b;
  ic_tag_req_t    ic_tag;
  ic_tag_rdata_t  ic_tag_rdata;
  ic_data_req_t   ic_data;
  ic_line_rdata_t ic_data_rdata;

  // Model state
  logic      m_fe;
  logic      m_busy;
  reg_data_t m_rf [NumRegs];
  reg_data_t m_shadow;
  ic_tag_t   m_tag [IC_NUM_WAYS][IC_NUM_LINES];
  ic_line_t  m_line [IC_NUM_WAYS][IC_NUM_LINES];
  ic_tag_t   m_tag_rd [IC_NUM_WAYS];
  ic_line_t  m_line_rd [IC_NUM_WAYS];

  integer      seed;
  logic [31:0] r;

  always #10 clk = ~clk;

  core_shell_top u_dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .test_en_i       (test_en),
    .fetch_enable_i  (fetch_enable),
    .core_busy_i     (core_busy),
    .wake_i          (wake),
    .core_sleep_o    (core_sleep),
    .rf_req_i        (rf_req),
    .rf_rdata_a_o    (rf_rdata_a),
    .rf_rdata_b_o    (rf_rdata_b),
    .ic_tag_i        (ic_tag),
    .ic_tag_rdata_o  (ic_tag_rdata),
    .ic_data_i       (ic_data),
    .ic_data_rdata_o (ic_data_rdata)
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("Fail at %0d ns: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "Mismatch against model");
  endtask

  task automatic check_sleep(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_tag(input ic_tag_t got, input ic_tag_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_line(input ic_line_t got, input ic_line_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  function automatic reg_data_t model_read(input reg_addr_t addr, input logic dummy);
    if (addr == '0) begin
      model_read = dummy ? m_shadow : '0;
    end else begin
      model_read = m_rf[addr];
    end
  endfunction

  // Checks the settled outputs, then steps the model over one rising edge
  task automatic run_cycle();
    logic clock_en;
    logic gated;
    clock_en = m_fe & (m_busy | wake.debug_req | wake.irq_pending | wake.irq_nm);
    gated    = clock_en | test_en;
    #1;
    check_sleep(core_sleep, ~clock_en, "core_sleep_o");
    check_reg(rf_rdata_a, model_read(rf_req.raddr_a, rf_req.dummy_instr), "rf port a");
    check_reg(rf_rdata_b, model_read(rf_req.raddr_b, rf_req.dummy_instr), "rf port b");
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      check_tag(ic_tag_rdata[w], m_tag_rd[w], $sformatf("tag rdata way %0d", w));
      check_line(ic_data_rdata[w], m_line_rd[w], $sformatf("line rdata way %0d", w));
    end
    @(posedge clk);
    if (gated && rf_req.we) begin
      if (rf_req.waddr != '0) begin
        m_rf[rf_req.waddr] = rf_req.wdata;
      end else if (rf_req.dummy_instr) begin
        m_shadow = rf_req.wdata;
      end
    end
    m_fe   = m_fe | fetch_enable;
    m_busy = core_busy;
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      if (ic_tag.req[w]) begin
        if (ic_tag.write) begin
          m_tag[w][ic_tag.addr] = ic_tag.wdata;
        end else begin
          m_tag_rd[w] = m_tag[w][ic_tag.addr];
        end
      end
      if (ic_data.req[w]) begin
        if (ic_data.write) begin
          m_line[w][ic_data.addr] = ic_data.wdata;
        end else begin
          m_line_rd[w] = m_line[w][ic_data.addr];
        end
      end
    end
    @(negedge clk);
  endtask

  task automatic random_rf_req(input logic dummy);
    r = $random(seed);
    rf_req.dummy_instr = dummy;
    rf_req.raddr_a     = r[4:0];
    rf_req.raddr_b     = r[9:5];
    rf_req.waddr       = r[14:10];
    rf_req.we          = r[15];
    r = $random(seed);
    rf_req.wdata       = r;
  endtask

  task automatic random_ic_words();
    r = $random(seed);
    ic_tag.wdata          = r[21:0];
    ic_data.wdata[63:32]  = r;
    r = $random(seed);
    ic_data.wdata[31:0]   = r;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    seed         = 32'ha1110bd4;
    rst_n        = 1'b0;
    test_en      = 1'b0;
    fetch_enable = 1'b0;
    core_busy    = 1'b0;
    wake         = '0;
    rf_req       = '0;
    ic_tag       = '0;
    ic_data      = '0;
    m_fe         = 1'b0;
    m_busy       = 1'b0;
    m_shadow     = '0;
    for (int i = 0; i < NumRegs; i++) begin
      m_rf[i] = '0;
    end
    for (int w = 0; w < IC_NUM_WAYS; w++) begin
      m_tag_rd[w]  = '0;
      m_line_rd[w] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Sleep rule with fetch enable held off for the first cycles
    for (int i = 0; i < SleepCycles; i++) begin
      r = $random(seed);
      fetch_enable = (i >= 20) && (r[2:0] == 3'd0);
      core_busy    = r[3];
      wake         = r[6:4] & r[9:7];
      random_rf_req(1'b0);
      if (i < 20) begin
        #1;
        check_sleep(core_sleep, 1'b1, "core_sleep_o before fetch enable");
      end
      run_cycle();
    end

    // Writes while the clock toggles on and off, test enable now and then
    fetch_enable = 1'b1;
    for (int i = 0; i < GatedCycles; i++) begin
      random_rf_req(1'b0);
      rf_req.we = 1'b1;
      r = $random(seed);
      core_busy = (r[1:0] == 2'd0);
      wake      = r[4:2] & r[7:5] & r[10:8];
      test_en   = (r[12:11] == 2'd0);
      run_cycle();
    end

    test_en   = 1'b0;
    core_busy = 1'b1;
    wake      = '0;
    for (int i = 0; i < RfCycles; i++) begin
      random_rf_req(1'b0);
      run_cycle();
    end

    // Shadow register 0 during dummy instructions
    rf_req             = '0;
    rf_req.dummy_instr = 1'b1;
    rf_req.we          = 1'b1;
    r = $random(seed);
    rf_req.wdata       = r;
    run_cycle();
    rf_req.we = 1'b0;
    #1;
    check_reg(rf_rdata_a, r, "r0 during dummy instruction");
    run_cycle();
    rf_req.dummy_instr = 1'b0;
    #1;
    check_reg(rf_rdata_a, '0, "r0 outside dummy instruction");
    run_cycle();
    rf_req.we    = 1'b1;
    rf_req.wdata = ~r;
    run_cycle();
    rf_req.we          = 1'b0;
    rf_req.dummy_instr = 1'b1;
    #1;
    check_reg(rf_rdata_a, r, "r0 shadow after dummy instruction resumes");
    run_cycle();
    for (int i = 0; i < DummyCycles; i++) begin
      random_rf_req(1'b0);
      rf_req.dummy_instr = rf_req.wdata[31];
      if (rf_req.wdata[30]) begin
        rf_req.waddr = '0;
      end
      if (rf_req.wdata[29]) begin
        rf_req.raddr_a = '0;
      end
      run_cycle();
    end

    // Fill both ways of every line before random traffic
    rf_req = '0;
    for (int i = 0; i < IC_NUM_LINES; i++) begin
      random_ic_words();
      ic_tag.req   = '1;
      ic_tag.write = 1'b1;
      ic_tag.addr  = ic_index_t'(i);
      ic_data.req   = '1;
      ic_data.write = 1'b1;
      ic_data.addr  = ic_index_t'(i);
      run_cycle();
    end
    for (int i = 0; i < CacheCycles; i++) begin
      r = $random(seed);
      ic_tag.req    = r[1:0];
      ic_tag.write  = r[2] & r[3];
      ic_tag.addr   = r[11:4];
      ic_data.req   = r[13:12];
      ic_data.write = r[14] & r[15];
      ic_data.addr  = r[23:16];
      random_ic_words();
      run_cycle();
    end
    ic_tag  = '0;
    ic_data = '0;
    run_cycle();

    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired, the run did not finish within %0d ns", TimeoutNs);
    $display("*** FAILED ***");
    $fatal(1, "Simulation hang");
  end

endmodule

/* bench/core_shell_sva.sv */
// Core shell assertions
// Sleep output after reset and tag RAM read data hold

`timescale 1ns/1ps

module core_shell_sva import core_shell_pkg::*; (
  input logic          clk_i,
  input logic          rst_ni,
  input logic          fetch_enable_i,
  input logic          core_sleep_o,
  input ic_tag_req_t   ic_tag_i,
  input ic_tag_rdata_t ic_tag_rdata_o
);

  logic fe_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fe_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fe_seen_q <= 1'b1;
    end
  end

  sleep_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(core_sleep_o))
    else $error("core_sleep_o is unknown after reset");

  // No fetch enable yet, so the core clock stays off
  sleep_before_fetch_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fe_seen_q |-> core_sleep_o)
    else $error("core_sleep_o low before fetch enable was seen");

  tag_rdata_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ic_tag_i.req == '0) |=> $stable(ic_tag_rdata_o))
    else $error("tag read data changed without a request");

endmodule

bind core_shell_top core_shell_sva u_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .fetch_enable_i (fetch_enable_i),
  .core_sleep_o   (core_sleep_o),
  .ic_tag_i       (ic_tag_i),
  .ic_tag_rdata_o (ic_tag_rdata_o)
);

/* hdl/core_shell_top.sv */
// Core shell top level
// Sleep control with clock gate, gated register file and cache RAM banks

`timescale 1ns/1ps
`include "core_shell_config.svh"

module core_shell_top import core_shell_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           test_en_i,

  // Sleep control
  input  logic           fetch_enable_i,
  input  logic           core_busy_i,
  input  wake_req_t      wake_i,
  output logic           core_sleep_o,

  // Register file
  input  rf_req_t        rf_req_i,
  output reg_data_t      rf_rdata_a_o,
  output reg_data_t      rf_rdata_b_o,

  // Instruction cache RAMs
  input  ic_tag_req_t    ic_tag_i,
  output ic_tag_rdata_t  ic_tag_rdata_o,
  input  ic_data_req_t   ic_data_i,
  output ic_line_rdata_t ic_data_rdata_o
);

  logic clk_core;

  //////////////////////////////////////////////////
  // Main clock gate
  //////////////////////////////////////////////////

  sleep_ctrl u_sleep_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .test_en_i      (test_en_i),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_i    (core_busy_i),
    .wake_i         (wake_i),
    .core_sleep_o   (core_sleep_o),
    .clk_core_o     (clk_core)
  );

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  // Only runs while the core clock is on
  register_file_ff #(
    .NumWords (`CFG_RF_WORDS)
  ) u_register_file (
    .clk_i     (clk_core),
    .rst_ni    (rst_ni),
    .req_i     (rf_req_i),
    .rdata_a_o (rf_rdata_a_o),
    .rdata_b_o (rf_rdata_b_o)
  );

  //////////////////////////////////////////////////
  // Cache RAMs
  //////////////////////////////////////////////////

  // Cache fills continue on the free-running clock while the core sleeps
  ic_ram_banks u_ic_ram_banks (
    .clk_i        (clk_i),
    .tag_i        (ic_tag_i),
    .tag_rdata_o  (ic_tag_rdata_o),
    .data_i       (ic_data_i),
    .data_rdata_o (ic_data_rdata_o)
  );

endmodule

/* icache_rams/ic_ram_banks.sv */
// Instruction cache RAM banks
// One tag bank and one data bank per way, sharing address and write data

`timescale 1ns/1ps

module ic_ram_banks import core_shell_pkg::*; (
  input  logic           clk_i,
  input  ic_tag_req_t    tag_i,
  output ic_tag_rdata_t  tag_rdata_o,
  input  ic_data_req_t   data_i,
  output ic_line_rdata_t data_rdata_o
);

  localparam int unsigned TagW  = $bits(ic_tag_t);
  localparam int unsigned LineW = $bits(ic_line_t);

  for (genvar w = 0; w < IC_NUM_WAYS; w++) begin : gen_ways
    logic tag_req;
    logic data_req;

    // Each way only sees its own request bit
    assign tag_req  = tag_i.req[w];
    assign data_req = data_i.req[w];

    ic_ram_1p #(
      .Width (TagW),
      .Depth (IC_NUM_LINES)
    ) u_tag_bank (
      .clk_i   (clk_i),
      .req_i   (tag_req),
      .write_i (tag_i.write),
      .addr_i  (tag_i.addr),
      .wdata_i (tag_i.wdata),
      .rdata_o (tag_rdata_o[w])
    );

    ic_ram_1p #(
      .Width (LineW),
      .Depth (IC_NUM_LINES)
    ) u_data_bank (
      .clk_i   (clk_i),
      .req_i   (data_req),
      .write_i (data_i.write),
      .addr_i  (data_i.addr),
      .wdata_i (data_i.wdata),
      .rdata_o (data_rdata_o[w])
    );
  end

endmodule

/* icache_rams/ic_ram_1p.sv */
// Single-port synchronous RAM
// Read data is registered and held until the next read

`timescale 1ns/1ps

module ic_ram_1p import core_shell_pkg::*; #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 256
) (
  input  logic             clk_i,
  input  logic             req_i,
  input  logic             write_i,
  input  ic_index_t        addr_i,
  input  logic [Width-1:0] wdata_i,
  output logic [Width-1:0] rdata_o
);

  logic [Width-1:0] mem [Depth];
  // Read data is zero until the first read
  logic [Width-1:0] rdata_q = '0;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* regfile/register_file_ff.sv */
// Flip-flop register file
// Two combinational read ports, one write port; register 0 is zero
// except during a dummy instruction, when it reads a shadow register

`timescale 1ns/1ps
`include "core_shell_config.svh"

module register_file_ff import core_shell_pkg::*; #(
  parameter int unsigned NumWords = `CFG_RF_WORDS
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rf_req_t   req_i,
  output reg_data_t rdata_a_o,
  output reg_data_t rdata_b_o
);

  logic [NumWords-1:0] we_dec;
  reg_data_t           rf_q [1:NumWords-1];
  reg_data_t           r0_dummy_q;
  reg_data_t           rf_view [NumWords];

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////

  // Indices beyond the register count are dropped
  always_comb begin
    we_dec = '0;
    if (req_i.we && (32'(req_i.waddr) < NumWords)) begin
      we_dec[req_i.waddr] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NumWords; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NumWords; i++) begin
        if (we_dec[i]) begin
          rf_q[i] <= req_i.wdata;
        end
      end
    end
  end

  // Shadow of register 0, only written by dummy instructions
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r0_dummy_q <= '0;
    end else if (we_dec[0] && req_i.dummy_instr) begin
      r0_dummy_q <= req_i.wdata;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  always_comb begin
    rf_view[0] = req_i.dummy_instr ? r0_dummy_q : '0;
    for (int i = 1; i < NumWords; i++) begin
      rf_view[i] = rf_q[i];
    end
  end

  assign rdata_a_o = (32'(req_i.raddr_a) < NumWords) ? rf_view[req_i.raddr_a] : '0;
  assign rdata_b_o = (32'(req_i.raddr_b) < NumWords) ? rf_view[req_i.raddr_b] : '0;

endmodule

/* hdl/sleep_ctrl.sv */
// Sleep control and main clock gate
// Runs the core clock once fetch is enabled and the core is busy or woken

`timescale 1ns/1ps

module sleep_ctrl import core_shell_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      test_en_i,
  input  logic      fetch_enable_i,
  input  logic      core_busy_i,
  input  wake_req_t wake_i,
  output logic      core_sleep_o,
  output logic      clk_core_o
);

  logic fetch_enable_q;
  logic busy_q;
  logic wake_any;
  logic clock_en;
  logic en_latch;

  // Fetch enable is sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  assign wake_any     = wake_i.debug_req | wake_i.irq_pending | wake_i.irq_nm;
  assign clock_en     = fetch_enable_q & (busy_q | wake_any);
  assign core_sleep_o = ~clock_en;

  //////////////////////////////////////////////////
  // Clock gate
  //////////////////////////////////////////////////

  // Enable settles while the clock is low, so no glitch on the high phase
  always_latch begin
    if (!clk_i) begin
      en_latch = clock_en | test_en_i;
    end
  end

  assign clk_core_o = clk_i & en_latch;

endmodule

/* common/core_shell_pkg.sv */
// Core shell types
// Register file request, wake sources and cache RAM bank requests

package core_shell_pkg;

  `include "core_shell_config.svh"

  localparam int unsigned IC_NUM_WAYS  = `CFG_IC_NUM_WAYS;
  localparam int unsigned IC_NUM_LINES = 2 ** `CFG_IC_INDEX_W;

  // Register file
  typedef logic [`CFG_XLEN-1:0]      reg_data_t;
  typedef logic [`CFG_RF_ADDR_W-1:0] reg_addr_t;

  typedef struct packed {
    logic      dummy_instr;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    reg_addr_t waddr;
    logic      we;
    reg_data_t wdata;
  } rf_req_t;

  // Sources that wake a sleeping core
  typedef struct packed {
    logic debug_req;
    logic irq_pending;
    logic irq_nm;
  } wake_req_t;

  //////////////////////////////////////////////////
  // Instruction cache RAMs
  //////////////////////////////////////////////////

  typedef logic [IC_NUM_WAYS-1:0]     ic_way_mask_t;
  typedef logic [`CFG_IC_INDEX_W-1:0] ic_index_t;
  typedef logic [`CFG_IC_TAG_W-1:0]   ic_tag_t;
  typedef logic [`CFG_IC_LINE_W-1:0]  ic_line_t;

  typedef struct packed {
    ic_way_mask_t req;
    logic         write;
    ic_index_t    addr;
    ic_tag_t      wdata;
  } ic_tag_req_t;

  typedef struct packed {
    ic_way_mask_t req;
    logic         write;
    ic_index_t    addr;
    ic_line_t     wdata;
  } ic_data_req_t;

  typedef ic_tag_t  [IC_NUM_WAYS-1:0] ic_tag_rdata_t;
  typedef ic_line_t [IC_NUM_WAYS-1:0] ic_line_rdata_t;

endpackage

/* common/core_shell_config.svh */
// Core shell configuration
// Data width, register count and instruction-cache geometry

`ifndef CORE_SHELL_CONFIG_SVH
`define CORE_SHELL_CONFIG_SVH

// Register file
`define CFG_XLEN        32
// Use 16 for RV32E
`define CFG_RF_WORDS    32
`define CFG_RF_ADDR_W   5

//////////////////////////////////////////////////
// Instruction cache geometry
//////////////////////////////////////////////////

`define CFG_IC_NUM_WAYS 2
// 256 lines per way
`define CFG_IC_INDEX_W  8
`define CFG_IC_TAG_W    22
`define CFG_IC_LINE_W   64

`endif
